//--- dram_bridge_top.f
design/dram_bridge_pkg.sv
design/dram_req_if.sv
design/dma_req_mapper.sv
design/dram_req_fifo.sv
design/dram_channel_model.sv
design/dram_bridge_top.sv
testbench/tb_clk_gen.sv
testbench/dram_bridge_sva.sv
testbench/dram_bridge_tb.sv

//--- Makefile
# Verilator build and run for the DMA to DRAM bridge

VERILATOR ?= verilator
TOP       ?= dram_bridge_tb
FILELIST  ?= dram_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx 'Everything OK' $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/dram_bridge_tb.sv
`timescale 1ns/1ps

module dram_bridge_tb;

  localparam int clk_period_lp = 20;
  localparam int fifo_els_lp = 4;
  localparam int random_ops_lp = 200;
  localparam int accept_limit_lp = 64;
  localparam int drain_limit_lp = 200;
  // rough cycle count of all tests, doubled for the watchdog
  localparam int est_cycles_lp = 300 + random_ops_lp * 8;

  logic core_clk;
  logic arst_n;
  logic dma_pkt_v_i;
  logic dma_pkt_write_i;
  logic [13:0] dma_pkt_addr_i;
  logic dma_pkt_yumi_o;
  logic dma_wdata_v_i;
  logic [31:0] dma_wdata_i;
  logic dma_wdata_yumi_o;
  logic dma_rdata_v_o;
  logic [31:0] dma_rdata_o;
  logic dma_rdata_ready_i;

  integer seed = 32'h2149;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int reads_checked = 0;
  logic ready_random = 1'b0;
  logic ready_level = 1'b1;

  // reference memory indexed by address bits 13:2
  logic [31:0] ref_mem [4096];
  logic [31:0] exp_q [$];
  logic [13:0] written [$];

  tb_clk_gen #(.period_p(clk_period_lp), .reset_cycles_p(3)) clk_gen (
    .core_clk(core_clk)
    ,.arst_n_o(arst_n)
  );

  dram_bridge_top #(.fifo_els_p(fifo_els_lp)) UUT (
    .core_clk(core_clk)
    ,.arst_n_i(arst_n)
    ,.dma_pkt_v_i(dma_pkt_v_i)
    ,.dma_pkt_write_i(dma_pkt_write_i)
    ,.dma_pkt_addr_i(dma_pkt_addr_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.dma_wdata_v_i(dma_wdata_v_i)
    ,.dma_wdata_i(dma_wdata_i)
    ,.dma_wdata_yumi_o(dma_wdata_yumi_o)
    ,.dma_rdata_v_o(dma_rdata_v_o)
    ,.dma_rdata_o(dma_rdata_o)
    ,.dma_rdata_ready_i(dma_rdata_ready_i)
  );

  // next ready level picked on the rising edge, driven on the falling edge
  initial begin : ready_driver
    logic [31:0] r;
    logic next_ready;
    dma_rdata_ready_i = 1'b1;
    forever begin
      @(posedge core_clk);
      r = $random(seed);
      next_ready = ready_random ? (r[1:0] != 2'b00) : ready_level;
      @(negedge core_clk);
      dma_rdata_ready_i = next_ready;
    end
  end

  // compares every taken return word against the expected queue
  initial begin : rdata_monitor
    logic [31:0] exp;
    forever begin
      @(negedge core_clk);
      #2;
      if (dma_rdata_v_o && dma_rdata_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("read data %h returned with no read outstanding", dma_rdata_o);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          reads_checked++;
          if (dma_rdata_o !== exp) begin
            $display("error dma_rdata_o: expected %h, got %h", exp, dma_rdata_o);
            errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(2 * est_cycles_lp * clk_period_lp);
    $display("timeout: run did not finish within %0d cycles", 2 * est_cycles_lp);
    $display("Something failed");
    $finish;
  end

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("error %s: expected 0, got %h", name, value);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic idle_cycle();
    @(negedge core_clk);
    dma_pkt_v_i = 1'b0;
    dma_wdata_v_i = 1'b0;
  endtask

  // one cycle of a request, logged in the reference when accepted
  task automatic try_issue(input logic write, input logic [13:0] addr,
                           input logic [31:0] data, output logic accepted);
    @(negedge core_clk);
    dma_pkt_v_i = 1'b1;
    dma_pkt_write_i = write;
    dma_pkt_addr_i = addr;
    dma_wdata_v_i = write;
    dma_wdata_i = write ? data : '0;
    #1;
    accepted = dma_pkt_yumi_o;
    if (accepted) begin
      if (dma_wdata_yumi_o !== write) begin
        $display("error dma_wdata_yumi_o: expected %h, got %h", write, dma_wdata_yumi_o);
        errors++;
      end
      if (write) begin
        ref_mem[addr[13:2]] = data;
      end else begin
        exp_q.push_back(ref_mem[addr[13:2]]);
      end
    end
  endtask

  task automatic issue(input logic write, input logic [13:0] addr, input logic [31:0] data);
    logic accepted;
    int tries;
    accepted = 1'b0;
    tries = 0;
    while (!accepted && tries < accept_limit_lp) begin
      try_issue(write, addr, data, accepted);
      tries++;
    end
    if (!accepted) begin
      $display("request to address %h was never accepted", addr);
      errors++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < drain_limit_lp) begin
      @(negedge core_clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d reads never returned their data", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic test_reset();
    int err_before;
    err_before = errors;
    repeat (2) @(negedge core_clk);
    #1;
    expect_low("dma_pkt_yumi_o", dma_pkt_yumi_o);
    expect_low("dma_wdata_yumi_o", dma_wdata_yumi_o);
    expect_low("dma_rdata_v_o", dma_rdata_v_o);
    wait (arst_n === 1'b1);
    @(negedge core_clk);
    #1;
    expect_low("dma_pkt_yumi_o", dma_pkt_yumi_o);
    expect_low("dma_wdata_yumi_o", dma_wdata_yumi_o);
    expect_low("dma_rdata_v_o", dma_rdata_v_o);
    report_test("reset", err_before);
  endtask

  task automatic test_write_read();
    int err_before;
    err_before = errors;
    issue(1'b1, 14'h2a5c, 32'h5eed_c0de);
    written.push_back(14'h2a5c);
    issue(1'b0, 14'h2a5c, '0);
    idle_cycle();
    wait_drain();
    report_test("write_read", err_before);
  endtask

  task automatic test_burst_order();
    int err_before;
    logic [13:0] addrs [8];
    err_before = errors;
    for (int k = 0; k < 8; k++) begin
      // distinct row per entry, other fields varied
      addrs[k] = {k[3:0], k[1:0], ~k[1:0], k[3:0] ^ 4'h5, 2'b00};
      issue(1'b1, addrs[k], $random(seed));
      written.push_back(addrs[k]);
    end
    for (int k = 0; k < 8; k++) begin
      issue(1'b0, addrs[k], '0);
    end
    idle_cycle();
    wait_drain();
    report_test("burst_order", err_before);
  endtask

  task automatic test_byte_alias();
    int err_before;
    err_before = errors;
    issue(1'b1, 14'h1231, 32'ha11a_5ed0);
    written.push_back(14'h1231);
    issue(1'b0, 14'h1232, '0);
    idle_cycle();
    wait_drain();
    report_test("byte_alias", err_before);
  endtask

  task automatic test_backpressure();
    int err_before;
    int accepted_n;
    logic acc;
    err_before = errors;
    accepted_n = 0;
    ready_level = 1'b0;
    for (int i = 0; i < fifo_els_lp + 8; i++) begin
      try_issue(1'b0, written[accepted_n % written.size()], '0, acc);
      if (acc) begin
        accepted_n++;
      end
    end
    if (accepted_n > fifo_els_lp + 2 || accepted_n == 0) begin
      $display("back-pressure let %0d reads in, limit is %0d", accepted_n, fifo_els_lp + 2);
      errors++;
    end
    ready_level = 1'b1;
    // the stalled request stays valid until it is taken
    issue(1'b0, written[accepted_n % written.size()], '0);
    idle_cycle();
    wait_drain();
    report_test("backpressure", err_before);
  endtask

  task automatic test_random();
    int err_before;
    int idx;
    logic [31:0] r;
    logic [31:0] data;
    err_before = errors;
    ready_random = 1'b1;
    for (int n = 0; n < random_ops_lp; n++) begin
      r = $random(seed);
      if (r[0]) begin
        data = $random(seed);
        r = $random(seed);
        issue(1'b1, r[13:0], data);
        written.push_back(r[13:0]);
      end else begin
        r = $random(seed);
        idx = int'(r[15:0]) % written.size();
        issue(1'b0, written[idx], '0);
      end
      r = $random(seed);
      repeat (int'(r[1:0]) % 3) idle_cycle();
    end
    idle_cycle();
    ready_random = 1'b0;
    ready_level = 1'b1;
    wait_drain();
    report_test("random", err_before);
  endtask

  initial begin
    dma_pkt_v_i = 1'b0;
    dma_pkt_write_i = 1'b0;
    dma_pkt_addr_i = '0;
    dma_wdata_v_i = 1'b0;
    dma_wdata_i = '0;
    test_reset();
    test_write_read();
    test_burst_order();
    test_byte_alias();
    test_backpressure();
    test_random();
    $display("tests %0d, failed %0d, reads checked %0d, errors %0d",
             tests_run, tests_failed, reads_checked, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- testbench/dram_bridge_sva.sv
`timescale 1ns/1ps

module dram_bridge_sva (
  input logic core_clk
  ,input logic arst_n_i
  ,input logic pkt_v_i
  ,input logic pkt_write_i
  ,input logic pkt_yumi_i
  ,input logic wdata_yumi_i
  ,input logic rdata_v_i
  ,input logic [dram_bridge_pkg::data_width_lp-1:0] rdata_i
  ,input logic rdata_ready_i
);

  // return data held until the cache takes it
  rdata_hold_a: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    rdata_v_i && !rdata_ready_i |=> rdata_v_i && $stable(rdata_i))
    else $error("read return changed before it was taken");

  pkt_yumi_a: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    pkt_yumi_i |-> pkt_v_i)
    else $error("packet accepted without a valid packet");

  // write data goes with its packet, reads take none
  wdata_yumi_a: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    wdata_yumi_i == (pkt_yumi_i && pkt_write_i))
    else $error("write data handshake out of step with the packet");

endmodule

bind dram_bridge_top dram_bridge_sva sva (
  .core_clk(core_clk)
  ,.arst_n_i(arst_n_i)
  ,.pkt_v_i(dma_pkt_v_i)
  ,.pkt_write_i(dma_pkt_write_i)
  ,.pkt_yumi_i(dma_pkt_yumi_o)
  ,.wdata_yumi_i(dma_wdata_yumi_o)
  ,.rdata_v_i(dma_rdata_v_o)
  ,.rdata_i(dma_rdata_o)
  ,.rdata_ready_i(dma_rdata_ready_i)
);

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_p = 20
  ,parameter int reset_cycles_p = 3
) (
  output logic core_clk
  ,output logic arst_n_o
);

  initial begin
    core_clk = 1'b0;
    forever #(period_p / 2) core_clk = ~core_clk;
  end

  // release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge core_clk);
    @(negedge core_clk);
    arst_n_o = 1'b1;
  end

endmodule

//--- design/dram_bridge_top.sv
`timescale 1ns/1ps

module dram_bridge_top #(
  parameter int fifo_els_p = 4
) (
  input logic core_clk
  ,input logic arst_n_i

  // request packets from the cache
  ,input logic dma_pkt_v_i
  ,input logic dma_pkt_write_i
  ,input logic [dram_bridge_pkg::cache_addr_width_lp-1:0] dma_pkt_addr_i
  ,output logic dma_pkt_yumi_o

  // write data
  ,input logic dma_wdata_v_i
  ,input logic [dram_bridge_pkg::data_width_lp-1:0] dma_wdata_i
  ,output logic dma_wdata_yumi_o

  // read return
  ,output logic dma_rdata_v_o
  ,output logic [dram_bridge_pkg::data_width_lp-1:0] dma_rdata_o
  ,input logic dma_rdata_ready_i
);

  dram_req_if map_q ();
  dram_req_if mem_q ();

  dma_req_mapper mapper (
    .core_clk(core_clk)
    ,.arst_n_i(arst_n_i)
    ,.dma_pkt_v_i(dma_pkt_v_i)
    ,.dma_pkt_write_i(dma_pkt_write_i)
    ,.dma_pkt_addr_i(dma_pkt_addr_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.dma_wdata_v_i(dma_wdata_v_i)
    ,.dma_wdata_i(dma_wdata_i)
    ,.dma_wdata_yumi_o(dma_wdata_yumi_o)
    ,.req_o(map_q.src)
  );

  dram_req_fifo #(
    .fifo_els_p(fifo_els_p)
  ) req_fifo (
    .core_clk(core_clk)
    ,.arst_n_i(arst_n_i)
    ,.enq_i(map_q.dst)
    ,.deq_o(mem_q.src)
  );

  dram_channel_model channel (
    .core_clk(core_clk)
    ,.arst_n_i(arst_n_i)
    ,.req_i(mem_q.dst)
    ,.dma_rdata_v_o(dma_rdata_v_o)
    ,.dma_rdata_o(dma_rdata_o)
    ,.dma_rdata_ready_i(dma_rdata_ready_i)
  );

endmodule

//--- design/dram_channel_model.sv
`timescale 1ns/1ps

module dram_channel_model (
  input logic core_clk
  ,input logic arst_n_i

  ,dram_req_if.dst req_i

  ,output logic dma_rdata_v_o
  ,output logic [dram_bridge_pkg::data_width_lp-1:0] dma_rdata_o
  ,input logic dma_rdata_ready_i
);

  import dram_bridge_pkg::*;

  localparam int mem_els_lp = 1 << ch_word_addr_width_lp;

  logic [data_width_lp-1:0] mem_r [mem_els_lp];

  logic [ch_word_addr_width_lp-1:0] word_addr;
  logic ret_free;
  logic take_write;
  logic take_read;

  logic rdata_v_r;
  logic [data_width_lp-1:0] rdata_r;

  // row, bank group, bank, column flattened into one word index
  assign word_addr = req_i.ch_addr;

  // return register empty or handed to the cache this cycle
  assign ret_free = ~rdata_v_r | dma_rdata_ready_i;

  assign take_write = req_i.v & (req_i.cmd == e_dram_write);
  assign take_read = req_i.v & (req_i.cmd == e_dram_read) & ret_free;

  assign req_i.yumi = take_write | take_read;

  always_ff @(posedge core_clk) begin
    if (take_write) begin
      mem_r[word_addr] <= req_i.wdata;
    end
  end

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_v_r <= 1'b0;
    end else if (take_read) begin
      rdata_v_r <= 1'b1;
    end else if (dma_rdata_ready_i) begin
      rdata_v_r <= 1'b0;
    end
  end

  // held until the cache takes it
  always_ff @(posedge core_clk) begin
    if (take_read) begin
      rdata_r <= mem_r[word_addr];
    end
  end

  assign dma_rdata_v_o = rdata_v_r;
  assign dma_rdata_o = rdata_r;

endmodule

//--- design/dram_req_fifo.sv
`timescale 1ns/1ps

module dram_req_fifo #(
  parameter int fifo_els_p = 4
) (
  input logic core_clk
  ,input logic arst_n_i

  ,dram_req_if.dst enq_i
  ,dram_req_if.src deq_o
);

  import dram_bridge_pkg::*;

  localparam int ptr_width_lp = $clog2(fifo_els_p);
  localparam int count_width_lp = $clog2(fifo_els_p + 1);

  typedef struct packed {
    dram_cmd_e cmd;
    dram_ch_addr_s ch_addr;
    logic [data_width_lp-1:0] wdata;
  } fifo_entry_s;

  fifo_entry_s mem_r [fifo_els_p];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [count_width_lp-1:0] count_r;

  logic full;
  logic empty;
  logic enq;
  logic deq;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_width_lp-1:0] ptr_next(
    input logic [ptr_width_lp-1:0] ptr
  );
    if (ptr == ptr_width_lp'(fifo_els_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_r == count_width_lp'(fifo_els_p));
  assign empty = (count_r == '0);

  assign enq_i.yumi = enq_i.v & ~full;
  assign enq = enq_i.yumi;
  assign deq = deq_o.yumi;

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ptr_next(wr_ptr_r);
      end
      if (deq) begin
        rd_ptr_r <= ptr_next(rd_ptr_r);
      end
      if (enq & ~deq) begin
        count_r <= count_r + 1'b1;
      end else if (deq & ~enq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= '{cmd: enq_i.cmd, ch_addr: enq_i.ch_addr, wdata: enq_i.wdata};
    end
  end

  // head entry read straight from storage
  assign deq_o.v = ~empty;
  assign deq_o.cmd = mem_r[rd_ptr_r].cmd;
  assign deq_o.ch_addr = mem_r[rd_ptr_r].ch_addr;
  assign deq_o.wdata = mem_r[rd_ptr_r].wdata;

endmodule

//--- design/dma_req_mapper.sv
`timescale 1ns/1ps

module dma_req_mapper (
  input logic core_clk
  ,input logic arst_n_i

  ,input logic dma_pkt_v_i
  ,input logic dma_pkt_write_i
  ,input logic [dram_bridge_pkg::cache_addr_width_lp-1:0] dma_pkt_addr_i
  ,output logic dma_pkt_yumi_o

  ,input logic dma_wdata_v_i
  ,input logic [dram_bridge_pkg::data_width_lp-1:0] dma_wdata_i
  ,output logic dma_wdata_yumi_o

  ,dram_req_if.src req_o
);

  import dram_bridge_pkg::*;

  logic slot_free;
  logic wdata_ok;
  logic accept;

  dram_ch_addr_s ch_addr_n;

  logic out_v_r;
  dram_cmd_e cmd_r;
  dram_ch_addr_s ch_addr_r;
  logic [data_width_lp-1:0] wdata_r;

  // output register is free or drains this cycle
  assign slot_free = ~out_v_r | req_o.yumi;

  // a read needs no data word
  assign wdata_ok = ~dma_pkt_write_i | dma_wdata_v_i;

  assign accept = dma_pkt_v_i & slot_free & wdata_ok;

  assign dma_pkt_yumi_o = accept;
  assign dma_wdata_yumi_o = accept & dma_pkt_write_i;

  // reorder cache address fields into channel order
  always_comb begin
    ch_addr_n.ro = dma_pkt_addr_i[ro_lsb_lp +: ro_width_lp];
    ch_addr_n.bg = dma_pkt_addr_i[bg_lsb_lp +: bg_width_lp];
    ch_addr_n.ba = dma_pkt_addr_i[ba_lsb_lp +: ba_width_lp];
    ch_addr_n.co = dma_pkt_addr_i[co_lsb_lp +: co_width_lp];
  end

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_v_r <= 1'b0;
    end else if (accept) begin
      out_v_r <= 1'b1;
    end else if (req_o.yumi) begin
      out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      cmd_r <= dma_pkt_write_i ? e_dram_write : e_dram_read;
      ch_addr_r <= ch_addr_n;
      wdata_r <= dma_pkt_write_i ? dma_wdata_i : '0;
    end
  end

  assign req_o.v = out_v_r;
  assign req_o.cmd = cmd_r;
  assign req_o.ch_addr = ch_addr_r;
  assign req_o.wdata = wdata_r;

endmodule

//--- design/dram_req_if.sv
`timescale 1ns/1ps

interface dram_req_if;

  import dram_bridge_pkg::*;

  logic v;
  dram_cmd_e cmd;
  dram_ch_addr_s ch_addr;
  logic [data_width_lp-1:0] wdata;
  logic yumi;

  // producer side
  modport src (
    output v
    ,output cmd
    ,output ch_addr
    ,output wdata
    ,input yumi
  );

  // consumer side
  modport dst (
    input v
    ,input cmd
    ,input ch_addr
    ,input wdata
    ,output yumi
  );

endinterface

//--- design/dram_bridge_pkg.sv
package dram_bridge_pkg;

  // datapath widths
  localparam int data_width_lp = 32;
  localparam int cache_addr_width_lp = 14;
  localparam int ch_word_addr_width_lp = 12;

  // channel address field widths
  localparam int ro_width_lp = 4;
  localparam int bg_width_lp = 2;
  localparam int ba_width_lp = 2;
  localparam int co_width_lp = 4;
  localparam int byte_offset_width_lp = 2;

  // cache byte address, from low bits to high
  //   [1:0]   byte offset, dropped since every access is a full word
  //   [5:2]   column
  //   [7:6]   bank
  //   [9:8]   bank group
  //   [13:10] row
  localparam int co_lsb_lp = byte_offset_width_lp;
  localparam int ba_lsb_lp = co_lsb_lp + co_width_lp;
  localparam int bg_lsb_lp = ba_lsb_lp + ba_width_lp;
  localparam int ro_lsb_lp = bg_lsb_lp + bg_width_lp;

  typedef enum logic {
    e_dram_read  = 1'b0,
    e_dram_write = 1'b1
  } dram_cmd_e;

  // channel order, row on top
  typedef struct packed {
    logic [ro_width_lp-1:0] ro;
    logic [bg_width_lp-1:0] bg;
    logic [ba_width_lp-1:0] ba;
    logic [co_width_lp-1:0] co;
  } dram_ch_addr_s;

endpackage
